// File: verilog.f
stream_pkg.sv
wb_pkg.sv
chan_if.sv
generic_fifo.sv
fifo_8_to_32.sv
byte_router.sv
word_arbiter.sv
readout_top.sv
readout_checker.sv
tb_readout.sv

// File: Makefile
SIM      = verilator
TOP      = tb_readout
FILELIST = verilog.f
FLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP)
RUNFLAGS = +verilator+error+limit+1000
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUNFLAGS) | tee $(LOG)
	@grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: tb_readout.sv
// --------------------------------------------------
// readout buffer testbench
// random byte stream, wishbone master, reference model
// --------------------------------------------------
`timescale 1ns/1ns

module tb_readout;

    import stream_pkg::*;
    import wb_pkg::*;

    localparam int n_tests        = 5;
    localparam int test_budget    = 600;                      // cycles per test.
    localparam int timeout_cycles = n_tests * test_budget + 1000;

    logic              CLK;
    logic              RST;
    logic              byte_valid;
    logic [chan_w-1:0] byte_chan;
    logic [7:0]        byte_data;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [adr_w-1:0]  wb_adr;
    logic [data_w-1:0] wb_wdata;
    logic [data_w-1:0] wb_rdata;
    logic              wb_ack;

    // ----------------------------------------------
    // reference model state
    // ----------------------------------------------
    logic [7:0]        pend_q [n_chan][$];    // bytes of the word being built.
    word_u             word_q [n_chan][$];    // complete words per channel.
    logic [n_chan-1:0] en_m;
    int                drop_m;
    logic [chan_w-1:0] last_m;

    logic [31:0] seed = 32'hf3393df1;
    int          cycles = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          test_err0 = 0;

    readout_top dut_i (
        .CLK        (CLK),
        .RST        (RST),
        .byte_valid (byte_valid),
        .byte_chan  (byte_chan),
        .byte_data  (byte_data),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_wdata   (wb_wdata),
        .wb_rdata   (wb_rdata),
        .wb_ack     (wb_ack)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    always @(posedge CLK) cycles <= cycles + 1;

    initial begin
        wait (cycles >= timeout_cycles);
        $display("timeout, run stopped after %0d cycles", cycles);
        $display("** FAIL **");
        $finish;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic expect_eq(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // a byte lands in the channel only while it is enabled.
    task automatic model_byte(input int ch, input logic [7:0] b);
        word_u w;
        if (en_m[ch]) begin
            pend_q[ch].push_back(b);
            if (pend_q[ch].size() == 4) begin
                w.word = {pend_q[ch][3], pend_q[ch][2], pend_q[ch][1], pend_q[ch][0]};
                word_q[ch].push_back(w);
                pend_q[ch].delete();
            end
        end else begin
            drop_m++;
        end
    endtask

    task automatic send_random(input int ch, input int n, input int gap);
        for (int i = 0; i < n; i++) begin
            seed       = lcg_next(seed);
            byte_valid = 1'b1;
            byte_chan  = chan_w'(ch);
            byte_data  = seed[23:16];
            model_byte(ch, seed[23:16]);
            @(posedge CLK);
            #5;
            byte_valid = 1'b0;
            repeat (gap) @(posedge CLK);
            if (gap > 0)
                #5;
        end
    endtask

    task automatic wb_xfer(input logic we, input logic [adr_w-1:0] adr,
                           input logic [31:0] wdata, output logic [31:0] rd);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_wdata = wdata;
        do begin
            @(posedge CLK);
            #5;
        end while (!wb_ack);
        rd     = wb_rdata;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic read_status(output logic [31:0] st);
        wb_xfer(1'b0, adr_status, '0, st);
    endtask

    task automatic write_ctrl(input logic [n_chan-1:0] en);
        logic [31:0] rd;
        wb_xfer(1'b1, adr_ctrl, 32'(en), rd);
        en_m = en;
    endtask

    // one cycle for the router stage and one for the drop counter.
    task automatic settle();
        repeat (2) @(posedge CLK);
        #5;
    endtask

    task automatic pop_check(output logic [31:0] rd);
        logic [31:0] st;
        word_u       exp_w;
        int          exp_ch;
        int          c;
        exp_ch     = -1;
        exp_w.word = '0;
        for (int k = 1; k <= n_chan; k++) begin
            c = (int'(last_m) + k) % n_chan;
            if (exp_ch < 0 && word_q[c].size() > 0)
                exp_ch = c;
        end
        if (exp_ch >= 0) begin
            do read_status(st); while (!st[exp_ch]);    // word may still be in the packer.
            exp_w  = word_q[exp_ch].pop_front();
            last_m = chan_w'(exp_ch);
        end
        wb_xfer(1'b0, adr_data, '0, rd);
        expect_eq("wb_rdata", rd, exp_w.word);
        read_status(st);
        expect_eq("status.last", 32'(st[st_last_msb:st_last_lsb]), 32'(last_m));
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s: %s, %0d errors", tests, name,
                 (errors == test_err0) ? "ok" : "failed", errors - test_err0);
        test_err0 = errors;
    endtask

    // ----------------------------------------------
    // test sequence
    // ----------------------------------------------
    initial begin : main
        logic [31:0] st;
        logic [31:0] rd;
        RST        = 1'b1;
        byte_valid = 1'b0;
        byte_chan  = '0;
        byte_data  = '0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_wdata   = '0;
        en_m       = '1;
        drop_m     = 0;
        last_m     = chan_w'(n_chan - 1);
        repeat (16) @(posedge CLK);
        #5;
        RST = 1'b0;

        send_random(0, 8, 0);
        do read_status(st); while (!st[0]);
        repeat (2) pop_check(rd);
        end_test("packing");

        for (int c = 1; c < n_chan; c++)
            send_random(c, 8, 0);
        repeat (6) pop_check(rd);
        end_test("round_robin");

        pop_check(rd);                                  // nothing stored anywhere.
        read_status(st);
        expect_eq("status.mask", 32'(st[st_mask_msb:st_mask_lsb]), '0);
        end_test("empty_read");

        write_ctrl(4'b1011);
        send_random(2, 8, 0);
        settle();
        read_status(st);
        expect_eq("status.drop", 32'(st[st_drop_msb:st_drop_lsb]), 32'(drop_m));
        expect_eq("status.mask", 32'(st[st_mask_msb:st_mask_lsb]), '0);
        write_ctrl('1);
        end_test("enable_mask");

        send_random(0, byte_depth + 4 * word_depth + 16, 1);
        settle();
        read_status(st);
        checks++;
        assert (int'(st[st_drop_msb:st_drop_lsb]) > drop_m) else begin
            $display("drop count did not rise during overflow, still %0d",
                     int'(st[st_drop_msb:st_drop_lsb]));
            errors++;
        end
        repeat (word_depth) pop_check(rd);
        end_test("overflow");

        errors += dut_i.arb_i.chk_i.fails;
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// File: readout_checker.sv
// --------------------------------------------------
// bus and drain rules of the word arbiter
// --------------------------------------------------
`timescale 1ns/1ns

module readout_checker (
    input logic                          CLK,
    input logic                          RST,
    input logic                          wb_cyc,
    input logic                          wb_stb,
    input logic                          wb_ack,
    input logic [stream_pkg::n_chan-1:0] rd_sel,
    input logic [stream_pkg::n_chan-1:0] not_empty
);

    int fails = 0;    // failed assertion count.

    // ack is a single cycle pulse.
    ack_one_cycle: assert property (@(posedge CLK) disable iff (RST)
        wb_ack |=> !wb_ack)
        else begin
            $error("wb_ack held high for more than one cycle");
            fails++;
        end

    // every ack answers a request seen on the cycle before.
    ack_after_req: assert property (@(posedge CLK) disable iff (RST)
        wb_ack |-> $past(wb_cyc && wb_stb && !wb_ack))
        else begin
            $error("wb_ack raised without a request");
            fails++;
        end

    one_read: assert property (@(posedge CLK) disable iff (RST)
        $onehot0(rd_sel))
        else begin
            $error("more than one channel read in the same cycle");
            fails++;
        end

    read_not_empty: assert property (@(posedge CLK) disable iff (RST)
        (rd_sel & ~not_empty) == '0)
        else begin
            $error("channel read while its word FIFO is empty");
            fails++;
        end

endmodule

bind word_arbiter readout_checker chk_i (
    .CLK       (CLK),
    .RST       (RST),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_ack    (wb_ack),
    .rd_sel    (rd_sel),
    .not_empty (not_empty)
);

// File: readout_top.sv
// --------------------------------------------------
// readout buffer top level
// router, four channel buffers and the bus arbiter
// --------------------------------------------------
`timescale 1ns/1ns

module readout_top (
    input  logic                          CLK,
    input  logic                          RST,
    input  logic                          byte_valid,
    input  logic [stream_pkg::chan_w-1:0] byte_chan,
    input  logic [7:0]                    byte_data,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [wb_pkg::adr_w-1:0]      wb_adr,
    input  logic [wb_pkg::data_w-1:0]     wb_wdata,
    output logic [wb_pkg::data_w-1:0]     wb_rdata,
    output logic                          wb_ack
);

    import stream_pkg::*;

    logic              drop;
    logic [n_chan-1:0] enable;

    chan_if ch_if [n_chan] ();

    byte_router router_i (
        .CLK        (CLK),
        .RST        (RST),
        .byte_valid (byte_valid),
        .byte_chan  (byte_chan),
        .byte_data  (byte_data),
        .enable     (enable),
        .drop       (drop),
        .ch         (ch_if)
    );

    // ----------------------------------------------
    // channel buffers
    // ----------------------------------------------
    for (genvar g = 0; g < n_chan; g++) begin : g_chan
        fifo_8_to_32 chan_i (
            .CLK (CLK),
            .RST (RST),
            .ch  (ch_if[g])
        );
    end

    word_arbiter arb_i (
        .CLK      (CLK),
        .RST      (RST),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_wdata (wb_wdata),
        .wb_rdata (wb_rdata),
        .wb_ack   (wb_ack),
        .drop     (drop),
        .enable   (enable),
        .ch       (ch_if)
    );

endmodule

// File: word_arbiter.sv
// --------------------------------------------------
// wishbone slave, round-robin word drain
// also holds the status and channel enable registers
// --------------------------------------------------
`timescale 1ns/1ns

module word_arbiter (
    input  logic                          CLK,
    input  logic                          RST,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [wb_pkg::adr_w-1:0]      wb_adr,
    input  logic [wb_pkg::data_w-1:0]     wb_wdata,
    output logic [wb_pkg::data_w-1:0]     wb_rdata,
    output logic                          wb_ack,
    input  logic                          drop,
    output logic [stream_pkg::n_chan-1:0] enable,
    chan_if.drain                         ch [stream_pkg::n_chan]
);

    import stream_pkg::*;
    import wb_pkg::*;

    localparam int drop_w = st_drop_msb - st_drop_lsb + 1;

    logic [n_chan-1:0] not_empty;
    logic [n_chan-1:0] rd_sel;
    word_u             words [n_chan];
    logic [chan_w-1:0] last_q;
    logic [chan_w-1:0] sel;
    logic [chan_w-1:0] idx;
    logic              found;
    logic [drop_w-1:0] drop_cnt;
    logic              req;
    logic              pop;
    logic [data_w-1:0] status;

    // ----------------------------------------------
    // channel side
    // ----------------------------------------------
    for (genvar g = 0; g < n_chan; g++) begin : g_drain
        assign not_empty[g]  = !ch[g].empty;
        assign words[g].word = ch[g].word;
        assign rd_sel[g]     = pop && (sel == chan_w'(g));
        assign ch[g].read    = rd_sel[g];
    end

    // search starts just after the last served channel and wraps.
    always_comb begin
        found = 1'b0;
        sel   = last_q;
        idx   = last_q;
        for (int k = 1; k <= n_chan; k++) begin
            idx = last_q + chan_w'(k);
            if (!found && not_empty[idx]) begin
                found = 1'b1;
                sel   = idx;
            end
        end
    end

    // ----------------------------------------------
    // bus decode
    // ----------------------------------------------
    assign req = wb_cyc && wb_stb && !wb_ack;   // new request only.
    assign pop = req && !wb_we && (wb_adr == adr_data) && found;

    always_comb begin
        status = '0;
        status[st_mask_msb:st_mask_lsb] = not_empty;
        status[st_last_msb:st_last_lsb] = last_q;
        status[st_drop_msb:st_drop_lsb] = drop_cnt;
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            wb_ack   <= 1'b0;
            enable   <= '1;                 // all channels on.
            drop_cnt <= '0;
            last_q   <= chan_w'(n_chan - 1); // first search starts at channel 0.
        end else begin
            wb_ack <= req;
            if (pop)
                last_q <= sel;
            if (req && wb_we && (wb_adr == adr_ctrl))
                enable <= wb_wdata[ctrl_en_msb:ctrl_en_lsb];
            if (drop && (drop_cnt != drop_w'(drop_max)))
                drop_cnt <= drop_cnt + 1'b1;  // saturating.
        end
    end

    // read data goes out with the ack.
    always_ff @(posedge CLK) begin
        if (req) begin
            case (wb_adr)
                adr_data:   wb_rdata <= found ? words[sel].word : '0;
                adr_status: wb_rdata <= status;
                adr_ctrl:   wb_rdata <= data_w'(enable);
                default:    wb_rdata <= '0;
            endcase
        end
    end

endmodule

// File: byte_router.sv
// --------------------------------------------------
// byte router, steers input bytes to the channels
// disabled or full targets turn into drop pulses
// --------------------------------------------------
`timescale 1ns/1ns

module byte_router (
    input  logic                        CLK,
    input  logic                        RST,
    input  logic                        byte_valid,
    input  logic [stream_pkg::chan_w-1:0] byte_chan,
    input  logic [7:0]                  byte_data,
    input  logic [stream_pkg::n_chan-1:0] enable,
    output logic                        drop,
    chan_if.feed                        ch [stream_pkg::n_chan]
);

    import stream_pkg::*;

    logic              vld_q;
    logic [chan_w-1:0] chan_q;
    logic [7:0]        data_q;
    logic [n_chan-1:0] accept;

    // input register stage.
    always_ff @(posedge CLK) begin
        if (RST)
            vld_q <= 1'b0;
        else
            vld_q <= byte_valid;
    end

    always_ff @(posedge CLK) begin
        chan_q <= byte_chan;
        data_q <= byte_data;
    end

    // full is checked on the write cycle itself, so no write is lost in flight.
    for (genvar g = 0; g < n_chan; g++) begin : g_feed
        assign accept[g]   = vld_q && (chan_q == chan_w'(g)) && enable[g] && !ch[g].full;
        assign ch[g].write = accept[g];
        assign ch[g].data  = data_q;
    end

    assign drop = vld_q && !(|accept);    // byte had nowhere to go.

endmodule

// File: fifo_8_to_32.sv
// --------------------------------------------------
// channel buffer, bytes in and 32 bit words out
// byte FIFO, four byte packer, word FIFO
// --------------------------------------------------
`timescale 1ns/1ns

module fifo_8_to_32 (
    input  logic CLK,
    input  logic RST,
    chan_if.chan ch
);

    import stream_pkg::*;

    logic        byte_empty;
    logic [7:0]  byte_out;
    logic        rd_byte;
    logic [1:0]  byte_cnt;
    logic        wait_word;
    logic        word_wr;
    logic        word_full;
    word_u       word_buf;

    // ----------------------------------------------
    // byte queue
    // ----------------------------------------------
    generic_fifo #(
        .WIDTH(8),
        .DEPTH(byte_depth)
    ) byte_fifo_i (
        .CLK      (CLK),
        .RST      (RST),
        .write    (ch.write),
        .read     (rd_byte),
        .data_in  (ch.data),
        .full     (ch.full),
        .empty    (byte_empty),
        .data_out (byte_out)
    );

    // ----------------------------------------------
    // packer
    // ----------------------------------------------
    assign rd_byte = !byte_empty && !wait_word;   // one byte per cycle.

    always_ff @(posedge CLK) begin
        if (RST) begin
            byte_cnt  <= '0;
            wait_word <= 1'b0;
        end else if (word_wr) begin
            byte_cnt  <= '0;                      // word handed over.
            wait_word <= 1'b0;
        end else if (rd_byte) begin
            if (byte_cnt == 2'd3)
                wait_word <= 1'b1;                // hold until the word FIFO takes it.
            else
                byte_cnt <= byte_cnt + 1'b1;
        end
    end

    // one cycle push, held off while the word FIFO is full.
    always_ff @(posedge CLK) begin
        if (RST)
            word_wr <= 1'b0;
        else
            word_wr <= wait_word && !word_wr && !word_full;
    end

    always_ff @(posedge CLK) begin
        if (rd_byte)
            word_buf.bytes[byte_cnt] <= byte_out;     // lsb first.
    end

    // ----------------------------------------------
    // word queue
    // ----------------------------------------------
    generic_fifo #(
        .WIDTH(32),
        .DEPTH(word_depth)
    ) word_fifo_i (
        .CLK      (CLK),
        .RST      (RST),
        .write    (word_wr),
        .read     (ch.read),
        .data_in  (word_buf.word),
        .full     (word_full),
        .empty    (ch.empty),
        .data_out (ch.word)
    );

endmodule

// File: generic_fifo.sv
// --------------------------------------------------
// synchronous show-ahead FIFO
// head entry is visible on data_out while not empty
// --------------------------------------------------
`timescale 1ns/1ns

module generic_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic             CLK,
    input  logic             RST,
    input  logic             write,
    input  logic             read,
    input  logic [WIDTH-1:0] data_in,
    output logic             full,
    output logic             empty,
    output logic [WIDTH-1:0] data_out
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count;
    logic             do_wr;
    logic             do_rd;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;   // wrap at the end.
    endfunction

    assign do_wr = write && !full;          // full FIFO ignores writes.
    assign do_rd = read && !empty;

    always_ff @(posedge CLK) begin
        if (RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_rd)
                rd_ptr <= next_ptr(rd_ptr);
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (do_wr)
            mem[wr_ptr] <= data_in;
    end

    assign full     = (count == (AW + 1)'(DEPTH));
    assign empty    = (count == '0);
    assign data_out = mem[rd_ptr];      // show-ahead read.

endmodule

// File: chan_if.sv
// --------------------------------------------------
// one channel link, byte write side and word read side
// --------------------------------------------------
`timescale 1ns/1ns

interface chan_if;

    // byte side.
    logic        write;
    logic [7:0]  data;
    logic        full;

    // word side, word is valid while empty is low.
    logic        read;
    logic        empty;
    logic [31:0] word;

    // router.
    modport feed (
        output write, data,
        input  full
    );

    // channel buffer.
    modport chan (
        input  write, data, read,
        output full, empty, word
    );

    // bus arbiter.
    modport drain (
        output read,
        input  empty, word
    );

endinterface

// File: wb_pkg.sv
// --------------------------------------------------
// wishbone register map of the readout buffer
// --------------------------------------------------
package wb_pkg;

    // bus widths.
    localparam int adr_w  = 2;
    localparam int data_w = 32;

    // address map.
    localparam logic [adr_w-1:0] adr_data   = 2'd0; // pop one word.
    localparam logic [adr_w-1:0] adr_status = 2'd1; // status, read only.
    localparam logic [adr_w-1:0] adr_ctrl   = 2'd2; // channel enables.

    // status fields.
    localparam int st_mask_lsb = 0;  // non-empty mask.
    localparam int st_mask_msb = 3;
    localparam int st_last_lsb = 4;  // last served channel.
    localparam int st_last_msb = 5;
    localparam int st_drop_lsb = 8;  // dropped byte count.
    localparam int st_drop_msb = 15;

    // control fields.
    localparam int ctrl_en_lsb = 0;
    localparam int ctrl_en_msb = 3;

    localparam int drop_max = 255;   // drop counter saturates here.

endpackage

// File: stream_pkg.sv
// --------------------------------------------------
// stream data path definitions
// channel count, FIFO depths and the packed word view
// --------------------------------------------------
package stream_pkg;

    // ----------------------------------------------
    // channel geometry
    // ----------------------------------------------
    localparam int n_chan = 4;      // number of channel buffers.
    localparam int chan_w = 2;      // bits of a channel number.

    // ----------------------------------------------
    // per channel storage
    // ----------------------------------------------
    localparam int byte_depth = 64; // byte FIFO entries.
    localparam int word_depth = 16; // word FIFO entries.

    // one 32 bit readout word.
    // the packer fills it byte by byte, the bus side reads it flat.
    typedef union packed {
        logic [31:0]     word;      // flat view.
        logic [3:0][7:0] bytes;     // byte 0 sits in bits 7:0.
    } word_u;

endpackage
